// ==== Makefile ====
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      := tb_spu_unit
FILELIST := project.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "test passed" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hdl/spu_carry_chain.sv ====
`timescale 1ns/10ps
`default_nettype none

// portable model of a device carry primitive
module spu_carry_chain #(
    parameter int WIDTH = 8
) (
    input  var logic             cin,     // carry into stage 0
    input  var logic [WIDTH-1:0] sin,     // propagate select
    input  var logic [WIDTH-1:0] din,     // generate value
    output var logic [WIDTH-1:0] dout,    // sum bits
    output var logic [WIDTH-1:0] cout     // carry out of each stage
);

    logic [WIDTH:0] carry;

    always_comb begin
        logic c;
        c = cin;
        carry[0] = c;
        for (int i = 0; i < WIDTH; i++) begin
            // mux per stage
            c = sin[i] ? c : din[i];
            carry[i+1] = c;
        end
    end

    always_comb begin
        for (int i = 0; i < WIDTH; i++) begin
            dout[i] = sin[i] ^ carry[i];
        end
    end

    assign cout = carry[WIDTH:1];

endmodule

`default_nettype wire

// ==== hdl/spu_op_addsub.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "spu_settings.svh"

module spu_op_addsub
    import spu_pkg::*;
(
    input  var logic  reset,
    input  var logic  clk,
    input  var logic  cke,

    input  var data_t s_data0,
    input  var data_t s_data1,
    input  var logic  s_sub,      // 1 selects data0 - data1
    input  var logic  s_clear,
    input  var logic  s_valid,

    output var data_t m_result,
    output var flag_t m_carry,
    output var logic  m_valid
);

    localparam int N = `SPU_DATA_BITS;

    logic [N-1:0] data1_mod;
    logic [N-1:0] chain_sin;
    logic [N-1:0] chain_sum;
    logic [N-1:0] chain_cout;
    logic [N:0]   st0_word;
    logic [N:0]   out_word;

    // two's complement subtract via inverted operand and carry-in
    assign data1_mod = s_sub ? ~s_data1 : s_data1;
    assign chain_sin = s_data0 ^ data1_mod;

    spu_carry_chain #(
        .WIDTH (N)
    ) carry_chain_i (
        .cin   (s_sub),
        .sin   (chain_sin),
        .din   (s_data0),
        .dout  (chain_sum),
        .cout  (chain_cout)
    );

    assign st0_word = {chain_cout[N-1], chain_sum};    // carry rides on top

    spu_op_nop #(
        .WIDTH   (N + 1),
        .LATENCY (`SPU_LATENCY)
    ) delay_i (
        .reset   (reset),
        .clk     (clk),
        .cke     (cke),
        .s_data  (st0_word),
        .s_clear (s_clear),
        .s_valid (s_valid),
        .m_data  (out_word),
        .m_valid (m_valid)
    );

    assign m_result = out_word[N-1:0];
    assign m_carry  = out_word[N];

endmodule

`default_nettype wire

// ==== hdl/spu_op_match.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "spu_settings.svh"

module spu_op_match
    import spu_pkg::*;
(
    input  var logic  reset,
    input  var logic  clk,
    input  var logic  cke,

    input  var data_t s_data0,
    input  var data_t s_data1,
    input  var logic  s_clear,
    input  var logic  s_valid,

    output var flag_t m_match    // 1 when operands equal
);

    localparam int CG        = `SPU_CARRY_GROUP;
    localparam int GROUPS    = (`SPU_DATA_BITS + CG - 1) / CG;
    localparam int PAD_WIDTH = GROUPS * CG;

    logic [PAD_WIDTH-1:0] diff;
    logic [GROUPS-1:0]    grp_sel;
    logic [GROUPS-1:0]    chain_cout;
    flag_t                st0_match;

    always_comb begin
        diff = '0;    // top partial group padded with agreeing bits
        diff[`SPU_DATA_BITS-1:0] = s_data0 ^ s_data1;
        for (int g = 0; g < GROUPS; g++) begin
            grp_sel[g] = ~|diff[g*CG +: CG];
        end
    end

    // carry survives only through agreeing groups
    spu_carry_chain #(
        .WIDTH (GROUPS)
    ) carry_chain_i (
        .cin   (1'b1),
        .sin   (grp_sel),
        .din   ('0),
        .dout  (),
        .cout  (chain_cout)
    );

    assign st0_match = chain_cout[GROUPS-1];

    spu_op_nop #(
        .WIDTH   ($bits(flag_t)),
        .LATENCY (`SPU_LATENCY)
    ) delay_i (
        .reset   (reset),
        .clk     (clk),
        .cke     (cke),
        .s_data  (st0_match),
        .s_clear (s_clear),
        .s_valid (s_valid),
        .m_data  (m_match),
        .m_valid ()
    );

endmodule

`default_nettype wire

// ==== hdl/spu_op_nop.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "spu_settings.svh"

module spu_op_nop
    import spu_pkg::*;
#(
    parameter int WIDTH   = $bits(data_t),
    parameter int LATENCY = `SPU_LATENCY    // at least 1
) (
    input  var logic             reset,
    input  var logic             clk,
    input  var logic             cke,

    input  var logic [WIDTH-1:0] s_data,
    input  var logic             s_clear,
    input  var logic             s_valid,

    output var logic [WIDTH-1:0] m_data,
    output var logic             m_valid
);

    logic [WIDTH-1:0]   data_q [LATENCY];
    logic [LATENCY-1:0] valid_q;
    logic [WIDTH-1:0]   data_in;

    assign data_in = s_clear ? '0 : s_data;    // clear value is zero

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
            for (int i = 0; i < LATENCY; i++) begin
                data_q[i] <= '0;
            end
        end else if (cke) begin
            data_q[0]  <= data_in;
            valid_q[0] <= s_valid;
            for (int i = 1; i < LATENCY; i++) begin
                data_q[i]  <= data_q[i-1];
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    assign m_data  = data_q[LATENCY-1];
    assign m_valid = valid_q[LATENCY-1];

endmodule

`default_nettype wire

// ==== hdl/spu_pkg.sv ====
`include "spu_settings.svh"

package spu_pkg;

    typedef logic signed [`SPU_DATA_BITS-1:0] data_t;
    typedef logic flag_t;
    typedef logic [1:0] op_t;

    localparam op_t OP_ADD   = 2'd0;
    localparam op_t OP_SUB   = 2'd1;
    localparam op_t OP_MATCH = 2'd2;

    typedef struct packed {
        op_t   op;
        data_t data0;
        data_t data1;
        logic  clear;     // zero this item's outputs
        logic  valid;
    } spu_in_t;

    typedef struct packed {
        data_t result;
        flag_t carry;     // no-borrow on subtract
        flag_t match;
        logic  valid;
    } spu_out_t;

endpackage

// ==== hdl/spu_settings.svh ====
`ifndef SPU_SETTINGS_SVH
`define SPU_SETTINGS_SVH

// operand and result width
`define SPU_DATA_BITS 16

// register stages from input to output
`define SPU_LATENCY 2

// operand bits folded into one carry stage by the match operator
`define SPU_CARRY_GROUP 3

`endif

// ==== hdl/spu_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "spu_settings.svh"

module spu_unit
    import spu_pkg::*;
(
    input  var logic     reset,
    input  var logic     clk,
    input  var logic     cke,

    input  var spu_in_t  s_in,
    output var spu_out_t m_out
);

    logic  sub_sel;
    flag_t match_flag;
    data_t addsub_result;
    flag_t addsub_carry;
    logic  addsub_valid;
    op_t   op_q;    // opcode aligned with results

    assign sub_sel = (s_in.op == OP_SUB);

    spu_op_match match_i (
        .reset   (reset),
        .clk     (clk),
        .cke     (cke),
        .s_data0 (s_in.data0),
        .s_data1 (s_in.data1),
        .s_clear (s_in.clear),
        .s_valid (s_in.valid),
        .m_match (match_flag)
    );

    spu_op_addsub addsub_i (
        .reset    (reset),
        .clk      (clk),
        .cke      (cke),
        .s_data0  (s_in.data0),
        .s_data1  (s_in.data1),
        .s_sub    (sub_sel),
        .s_clear  (s_in.clear),
        .s_valid  (s_in.valid),
        .m_result (addsub_result),
        .m_carry  (addsub_carry),
        .m_valid  (addsub_valid)
    );

    // opcode is never cleared, cleared operators already give zeros
    spu_op_nop #(
        .WIDTH   ($bits(op_t)),
        .LATENCY (`SPU_LATENCY)
    ) op_delay_i (
        .reset   (reset),
        .clk     (clk),
        .cke     (cke),
        .s_data  (s_in.op),
        .s_clear (1'b0),
        .s_valid (s_in.valid),
        .m_data  (op_q),
        .m_valid ()
    );

    always_comb begin
        m_out.valid = addsub_valid;
        m_out.match = match_flag;
        if (op_q == OP_MATCH) begin
            m_out.result    = '0;
            m_out.result[0] = match_flag;    // zero-extended flag
            m_out.carry     = 1'b0;
        end else begin
            m_out.result = addsub_result;
            m_out.carry  = addsub_carry;
        end
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+hdl
hdl/spu_pkg.sv
hdl/spu_carry_chain.sv
hdl/spu_op_nop.sv
hdl/spu_op_match.sv
hdl/spu_op_addsub.sv
hdl/spu_unit.sv
testbench/spu_unit_props.sv
testbench/tb_spu_unit.sv

// ==== testbench/spu_unit_props.sv ====
`timescale 1ns/10ps

`include "spu_settings.svh"

module spu_unit_props
    import spu_pkg::*;
(
    input var logic     clk,
    input var logic     reset,
    input var logic     cke,
    input var spu_in_t  s_in,
    input var spu_out_t m_out
);

    localparam int N = $bits(data_t);

    op_t op_pipe [`SPU_LATENCY];
    op_t out_op;    // opcode of the item now at m_out

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `SPU_LATENCY; i++) begin
                op_pipe[i] <= '0;
            end
        end else if (cke) begin
            op_pipe[0] <= s_in.op;
            for (int i = 1; i < `SPU_LATENCY; i++) begin
                op_pipe[i] <= op_pipe[i-1];
            end
        end
    end

    assign out_op = op_pipe[`SPU_LATENCY-1];

    // delay lines come out of reset empty
    valid_after_reset: assert property (
        @(posedge clk) reset |=> !m_out.valid
    ) else $error("m_out.valid high in the cycle after reset");

    stall_holds_output: assert property (
        @(posedge clk) disable iff (reset) !cke |=> $stable(m_out)
    ) else $error("m_out changed while cke was low");

    match_carry_zero: assert property (
        @(posedge clk) disable iff (reset)
        (m_out.valid && out_op == OP_MATCH) |-> !m_out.carry
    ) else $error("carry set on a match result");

    match_result_flag: assert property (
        @(posedge clk) disable iff (reset)
        (m_out.valid && out_op == OP_MATCH)
            |-> (m_out.result == {{(N-1){1'b0}}, m_out.match})
    ) else $error("match result is not the zero-extended flag");

endmodule

bind spu_unit spu_unit_props props_i (
    .clk   (clk),
    .reset (reset),
    .cke   (cke),
    .s_in  (s_in),
    .m_out (m_out)
);

// ==== testbench/spu_vectors.txt ====
# op data0 data1 clear result carry match, all hex
# op 0 add, 1 sub, 2 match
0 0001 0002 0 0003 0 0
0 1234 4321 0 5555 0 0
0 7fff 0001 0 8000 0 0
0 ffff 0001 0 0000 1 0
0 8000 8000 0 0000 1 1
0 ffff ffff 0 fffe 1 1
0 a5a5 5a5a 0 ffff 0 0
0 c000 7000 0 3000 1 0
0 0000 0000 0 0000 0 1
0 8001 fffe 0 7fff 1 0
0 7fff 0001 1 0000 0 0
1 0005 0003 0 0002 1 0
1 0003 0005 0 fffe 0 0
1 1234 1234 0 0000 1 1
1 8000 0001 0 7fff 1 0
1 0000 0001 0 ffff 0 0
1 7fff ffff 0 8000 0 0
1 ffff 0000 0 ffff 1 0
1 0000 0000 0 0000 1 1
1 abcd 1234 0 9999 1 0
1 1000 2000 0 f000 0 0
1 0003 0005 1 0000 0 0
2 1234 1234 0 0001 0 1
2 1234 1235 0 0000 0 0
2 1234 123c 0 0000 0 0
2 1234 1274 0 0000 0 0
2 1234 1334 0 0000 0 0
2 1234 1a34 0 0000 0 0
2 1234 1034 0 0000 0 0
2 1234 3234 0 0000 0 0
2 1234 9234 0 0000 0 0
2 ffff ffff 0 0001 0 1
2 0000 0010 0 0000 0 0
2 0000 0000 0 0001 0 1
2 5555 1555 0 0000 0 0
2 5555 5551 0 0000 0 0
2 abcd abcd 1 0000 0 0
2 ffff ffff 1 0000 0 0
0 0001 0001 0 0002 0 1

// ==== testbench/tb_spu_unit.sv ====
`timescale 1ns/10ps

`include "spu_settings.svh"

module tb_spu_unit
    import spu_pkg::*;
();

    localparam string VECTOR_FILE = "testbench/spu_vectors.txt";

    typedef struct packed {
        data_t result;
        flag_t carry;
        flag_t match;
    } expect_t;

    logic     clk = 1'b0;
    logic     reset;
    logic     cke;
    spu_in_t  s_in;
    spu_out_t m_out;

    spu_in_t     vec_in[$];
    expect_t     vec_exp[$];
    expect_t     exp_q[$];     // accepted items waiting for output
    string       name_q[$];
    logic [15:0] lfsr_state;
    int          accepted = 0;
    int          checked = 0;
    int          stall_left = 0;
    int          cycle_count = 0;
    int          cycle_limit = 1000;

    spu_unit spu_unit_i (
        .reset (reset),
        .clk   (clk),
        .cke   (cke),
        .s_in  (s_in),
        .m_out (m_out)
    );

    always #5 clk = ~clk;

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_data(input string test, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("mismatch %s expected %h actual %h",
                                        test, expected, actual));
        end
    endtask

    task automatic check_flag(input string test, input flag_t expected, input flag_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("mismatch %s expected %b actual %b",
                                        test, expected, actual));
        end
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    task automatic take_bits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic pick_cke();
        int bits;
        if (stall_left > 0) begin
            stall_left--;
            cke = 1'b0;
        end else begin
            take_bits(3, bits);
            if (bits == 7) begin
                take_bits(1, bits);
                stall_left = bits;    // one or two low cycles
                cke = 1'b0;
            end else begin
                cke = 1'b1;
            end
        end
    endtask

    function automatic string op_name(input op_t op);
        case (op)
            OP_ADD:   return "add";
            OP_SUB:   return "sub";
            OP_MATCH: return "match";
            default:  return "unknown";
        endcase
    endfunction

    task automatic load_vectors();
        int      fd;
        int      count;
        string   line;
        op_t     op_v;
        data_t   d0_v;
        data_t   d1_v;
        logic    clr_v;
        data_t   res_v;
        flag_t   carry_v;
        flag_t   match_v;
        spu_in_t item;
        expect_t want;
        fd = $fopen(VECTOR_FILE, "r");
        if (fd == 0) begin
            stop_with_failure({"could not open ", VECTOR_FILE});
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0) begin
                break;
            end
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            count = $sscanf(line, "%h %h %h %h %h %h %h",
                            op_v, d0_v, d1_v, clr_v, res_v, carry_v, match_v);
            if (count != 7) begin
                stop_with_failure({"malformed line in vector file: ", line});
            end else begin
                item = '0;
                item.op    = op_v;
                item.data0 = d0_v;
                item.data1 = d1_v;
                item.clear = clr_v;
                item.valid = 1'b1;
                want.result = res_v;
                want.carry  = carry_v;
                want.match  = match_v;
                vec_in.push_back(item);
                vec_exp.push_back(want);
            end
        end
        $fclose(fd);
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            stop_with_failure($sformatf("run did not finish within %0d cycles", cycle_limit));
        end
    end

    // cke changes 1 ns after the edge, so here it tells if the next edge consumes m_out
    always @(negedge clk) begin
        expect_t want;
        string   test;
        if (m_out.valid === 1'b1) begin
            if (accepted == 0) begin
                stop_with_failure("output valid before any item was accepted");
            end else if (cke === 1'b1) begin
                if (exp_q.size() == 0) begin
                    stop_with_failure("output valid with no item outstanding");
                end else begin
                    want = exp_q.pop_front();
                    test = name_q.pop_front();
                    check_data({test, " result"}, want.result, m_out.result);
                    check_flag({test, " carry"}, want.carry, m_out.carry);
                    check_flag({test, " match"}, want.match, m_out.match);
                    checked++;
                end
            end
        end
    end

    initial begin
        int idx;
        int idle_bits;
        reset = 1'b1;
        cke = 1'b0;
        s_in = '0;
        lfsr_state = 16'd3000;
        load_vectors();
        cycle_limit = vec_in.size() * 4 + 50;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        idx = 0;
        while (idx < vec_in.size()) begin
            pick_cke();
            take_bits(2, idle_bits);
            if (idle_bits == 3) begin
                s_in = '0;    // idle slot
            end else begin
                s_in = vec_in[idx];
            end
            @(posedge clk);
            if (cke && s_in.valid) begin
                exp_q.push_back(vec_exp[idx]);
                name_q.push_back($sformatf("vector %0d %s", idx, op_name(s_in.op)));
                accepted++;
                idx++;
            end
            #1;
        end
        s_in = '0;
        while (exp_q.size() > 0) begin
            pick_cke();
            @(posedge clk);
            #1;
        end
        cke = 1'b1;
        repeat (`SPU_LATENCY + 4) @(posedge clk);    // catch stray duplicates
        if (exp_q.size() != 0 || checked != vec_in.size()) begin
            stop_with_failure($sformatf("%0d of %0d items came out",
                                        checked, vec_in.size()));
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule
